// File: Makefile
VERILATOR ?= verilator
TOP       ?= sa_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --assert --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
src/sa_pkg.sv
src/sa_feed_if.sv
src/operand_ram.sv
src/sa_fetcher.sv
src/sa_pe.sv
src/sa_array.sv
src/result_shifter.sv
src/seg7_encoder.sv
src/sa_top.sv
tests/tb_clock.sv
tests/sa_assert.sv
tests/sa_tb.sv

// File: src/operand_ram.sv
`timescale 1ns/100ps

module operand_ram (
    input  logic                                              clk,
    input  logic                                              reset_n,
    input  logic                                              wr_en,
    input  logic [sa_pkg::addr_width-1:0]                     wr_addr,
    input  logic [sa_pkg::data_width-1:0]                     wr_data,
    output logic [sa_pkg::mem_size-1:0][sa_pkg::data_width-1:0] mem_view
);
    import sa_pkg::*;

    logic [data_width-1:0] mem [mem_size];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < mem_size; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Whole contents visible at once, no read latency
    always_comb begin
        for (int i = 0; i < mem_size; i++) begin
            mem_view[i] = mem[i];
        end
    end

endmodule

// File: src/result_shifter.sv
`timescale 1ns/100ps

module result_shifter (
    input  logic                                                              clk,
    input  logic                                                              reset_n,
    input  logic                                                              ready,
    input  logic [sa_pkg::array_w*sa_pkg::array_w-1:0][sa_pkg::res_width-1:0] results,
    output sa_pkg::result_word_t                                              current,
    output logic                                                              result_strobe
);
    import sa_pkg::*;

    localparam int n_results = array_w * array_w;

    logic [res_width-1:0]               buffer [n_results-1];
    logic [$clog2(n_results)-1:0]       remaining;
    logic [$clog2(display_ticks)-1:0]   tick;
    logic                               ready_d;
    logic                               armed;       // Skips the ready rise out of reset
    logic                               strobe_q;
    logic                               capture;

    assign capture = ready && !ready_d && armed;

    // ==================================================
    // Capture, then parallel-to-serial stepping
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ready_d   <= 1'b0;
            armed     <= 1'b0;
            remaining <= '0;
            tick      <= '0;
            strobe_q  <= 1'b0;
            current   <= '0;
        end else begin
            ready_d  <= ready;
            armed    <= armed | ready;
            strobe_q <= 1'b0;
            if (capture) begin
                current.word <= results[0];
                remaining    <= ($bits(remaining))'(n_results - 1);
                tick         <= '0;
                strobe_q     <= 1'b1;
            end else if (!ready) begin
                remaining <= '0;                // Restart abandons the display
            end else if (remaining != '0) begin
                tick <= tick + 1'b1;
                if (tick == ($bits(tick))'(display_ticks - 1)) begin
                    tick         <= '0;
                    current.word <= buffer[0];
                    remaining    <= remaining - 1'b1;
                    strobe_q     <= 1'b1;
                end
            end
        end
    end

    // Words still to show, shifted down one place per step
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int k = 0; k < n_results - 1; k++) begin
                buffer[k] <= results[k+1];
            end
        end else if (ready && remaining != '0
                     && tick == ($bits(tick))'(display_ticks - 1)) begin
            for (int k = 0; k < n_results - 2; k++) begin
                buffer[k] <= buffer[k+1];
            end
            buffer[n_results-2] <= '0;
        end
    end

    // A start seen in the step cycle drops ready before the strobe shows
    assign result_strobe = strobe_q && ready;

endmodule

// File: src/sa_array.sv
`timescale 1ns/100ps

module sa_array (
    input  logic                                                              clk,
    input  logic                                                              reset_n,
    sa_feed_if.array                                                          feed,
    output logic [sa_pkg::array_w*sa_pkg::array_w-1:0][sa_pkg::res_width-1:0] results
);
    import sa_pkg::*;

    // Column array_w of a_bus and row array_w of b_bus fall off the edge
    logic [data_width-1:0] a_bus [array_w][array_w+1];
    logic [data_width-1:0] b_bus [array_w+1][array_w];

    genvar i, j;

    generate
        for (i = 0; i < array_w; i++) begin : g_edge
            assign a_bus[i][0] = feed.feed_valid ? feed.a_edge[i] : '0;
            assign b_bus[0][i] = feed.feed_valid ? feed.b_edge[i] : '0;
        end

        for (i = 0; i < array_w; i++) begin : g_row
            for (j = 0; j < array_w; j++) begin : g_col
                sa_pe i_pe (
                    .clk     (clk),
                    .reset_n (reset_n),
                    .clear   (feed.clear),
                    .a_in    (a_bus[i][j]),
                    .b_in    (b_bus[i][j]),
                    .a_out   (a_bus[i][j+1]),
                    .b_out   (b_bus[i+1][j]),
                    .acc     (results[i*array_w + j])   // Row-major
                );
            end
        end
    endgenerate

endmodule

// File: src/sa_feed_if.sv
`timescale 1ns/100ps

interface sa_feed_if;
    import sa_pkg::*;

    logic [array_w-1:0][data_width-1:0] a_edge;  // One per row, left column
    logic [array_w-1:0][data_width-1:0] b_edge;  // One per column, top row
    logic                               feed_valid;
    logic                               clear;

    modport fetcher (
        output a_edge,
        output b_edge,
        output feed_valid,
        output clear
    );

    modport array (
        input a_edge,
        input b_edge,
        input feed_valid,
        input clear
    );

endinterface

// File: src/sa_fetcher.sv
`timescale 1ns/100ps

module sa_fetcher (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                start,
    input  logic [sa_pkg::mem_size-1:0][sa_pkg::data_width-1:0] a_mem,
    input  logic [sa_pkg::mem_size-1:0][sa_pkg::data_width-1:0] b_mem,
    output logic                                                ready,
    sa_feed_if.fetcher                                          feed
);
    import sa_pkg::*;

    logic [1:0]                                     state;
    logic [$clog2(array_l + 2*array_w - 2)-1:0]     step;

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= fetch_idle;
            step  <= '0;
            ready <= 1'b0;
        end else begin
            case (state)
                fetch_idle: begin
                    ready <= 1'b1;
                    if (start && ready) begin
                        state <= fetch_clear;
                        ready <= 1'b0;
                    end
                end
                fetch_clear: begin
                    step  <= '0;
                    state <= fetch_feed;
                end
                fetch_feed: begin
                    step <= step + 1'b1;
                    // Last operand pair reaches the far corner cell
                    if (step == ($bits(step))'(array_l + 2*array_w - 3)) begin
                        state <= fetch_drain;
                    end
                end
                default: begin                  // Drain, last products settle
                    state <= fetch_idle;
                    ready <= 1'b1;
                end
            endcase
        end
    end

    assign feed.clear      = (state == fetch_clear);
    assign feed.feed_valid = (state == fetch_feed);

    // Skewed diagonal: row i gets A[i][t-i], column j gets B[t-j][j]
    always_comb begin
        for (int i = 0; i < array_w; i++) begin
            feed.a_edge[i] = '0;
            feed.b_edge[i] = '0;
            if (step >= i && step < i + array_l) begin
                feed.a_edge[i] = a_mem[i*array_l + (step - i)];
                feed.b_edge[i] = b_mem[(step - i)*array_w + i];
            end
        end
    end

endmodule

// File: src/sa_pe.sv
`timescale 1ns/100ps

module sa_pe (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          clear,
    input  logic [sa_pkg::data_width-1:0] a_in,
    input  logic [sa_pkg::data_width-1:0] b_in,
    output logic [sa_pkg::data_width-1:0] a_out,
    output logic [sa_pkg::data_width-1:0] b_out,
    output logic [sa_pkg::res_width-1:0]  acc
);
    import sa_pkg::*;

    always_ff @(posedge clk) begin
        if (!reset_n || clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in;                      // To the right neighbor
            b_out <= b_in;                      // To the cell below
            acc   <= acc + a_in * b_in;         // Wraps at res_width
        end
    end

endmodule

// File: src/sa_pkg.sv
package sa_pkg;

    // ==================================================
    // Array and operand sizes
    // ==================================================
    localparam int data_width = 8;
    localparam int array_w    = 4;                   // Array side, also C side
    localparam int array_l    = 4;                   // Inner dimension
    localparam int mem_size   = array_w * array_l;
    localparam int res_width  = 2 * data_width;
    localparam int addr_width = 4;

    // Clock cycles between displayed results, short for simulation
    localparam int display_ticks = 8;

    // Fetcher state codes
    localparam logic [1:0] fetch_idle  = 2'd0;
    localparam logic [1:0] fetch_clear = 2'd1;
    localparam logic [1:0] fetch_feed  = 2'd2;
    localparam logic [1:0] fetch_drain = 2'd3;

    // ==================================================
    // One result word, seen whole or as hex digits
    // ==================================================
    typedef union packed {
        logic [res_width-1:0]          word;
        logic [res_width/4-1:0][3:0]   nibble;  // Nibble 0 is the low digit
    } result_word_t;

endpackage

// File: src/sa_top.sv
`timescale 1ns/100ps

module sa_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            wr_en,
    input  logic                            wr_sel,     // 0 = A, 1 = B
    input  logic [sa_pkg::addr_width-1:0]   wr_addr,
    input  logic [sa_pkg::data_width-1:0]   wr_data,
    input  logic                            start,
    output logic                            ready,
    output logic                            result_strobe,
    output logic [4*sa_pkg::data_width-1:0] hex_connect
);
    import sa_pkg::*;

    logic [mem_size-1:0][data_width-1:0]        a_mem;
    logic [mem_size-1:0][data_width-1:0]        b_mem;
    logic [array_w*array_w-1:0][res_width-1:0]  results;
    result_word_t                               current;
    logic                                       wr_en_a;
    logic                                       wr_en_b;

    sa_feed_if feed ();

    // Writes only land while idle
    assign wr_en_a = wr_en && ready && !wr_sel;
    assign wr_en_b = wr_en && ready && wr_sel;

    // ==================================================
    // Operands, fetcher and array
    // ==================================================
    operand_ram i_ram_a (
        .clk (clk), .reset_n (reset_n), .wr_en (wr_en_a),
        .wr_addr (wr_addr), .wr_data (wr_data), .mem_view (a_mem)
    );

    operand_ram i_ram_b (
        .clk (clk), .reset_n (reset_n), .wr_en (wr_en_b),
        .wr_addr (wr_addr), .wr_data (wr_data), .mem_view (b_mem)
    );

    sa_fetcher i_fetcher (
        .clk (clk), .reset_n (reset_n), .start (start),
        .a_mem (a_mem), .b_mem (b_mem), .ready (ready), .feed (feed.fetcher)
    );

    sa_array i_array (
        .clk (clk), .reset_n (reset_n), .feed (feed.array), .results (results)
    );

    // Display path
    result_shifter i_shifter (
        .clk (clk), .reset_n (reset_n), .ready (ready), .results (results),
        .current (current), .result_strobe (result_strobe)
    );

    seg7_encoder i_encoder (
        .value (current), .hex_connect (hex_connect)
    );

endmodule

// File: src/seg7_encoder.sv
`timescale 1ns/100ps

module seg7_encoder (
    input  sa_pkg::result_word_t              value,
    output logic [4*sa_pkg::data_width-1:0]   hex_connect
);
    import sa_pkg::*;

    // Active low, bit 0 = a up to bit 6 = g, bit 7 = dp kept off
    function automatic logic [7:0] seg_code(input logic [3:0] digit);
        case (digit)
            4'h0:    seg_code = 8'hC0;
            4'h1:    seg_code = 8'hF9;
            4'h2:    seg_code = 8'hA4;
            4'h3:    seg_code = 8'hB0;
            4'h4:    seg_code = 8'h99;
            4'h5:    seg_code = 8'h92;
            4'h6:    seg_code = 8'h82;
            4'h7:    seg_code = 8'hF8;
            4'h8:    seg_code = 8'h80;
            4'h9:    seg_code = 8'h90;
            4'hA:    seg_code = 8'h88;
            4'hB:    seg_code = 8'h83;
            4'hC:    seg_code = 8'hC6;
            4'hD:    seg_code = 8'hA1;
            4'hE:    seg_code = 8'h86;
            default: seg_code = 8'h8E;
        endcase
    endfunction

    always_comb begin
        for (int d = 0; d < res_width/4; d++) begin
            hex_connect[8*d +: 8] = seg_code(value.nibble[d]);   // Digit 0 in low byte
        end
    end

endmodule

// File: tests/sa_assert.sv
`timescale 1ns/100ps

module sa_assert (
    input logic                            clk,
    input logic                            reset_n,
    input logic                            start,
    input logic                            ready,
    input logic                            result_strobe,
    input logic [4*sa_pkg::data_width-1:0] hex_connect
);

    // An accepted start drops ready on the next edge
    start_drops_ready: assert property (@(posedge clk) disable iff (!reset_n)
        start && ready |=> !ready)
        else $error("ready stayed high after an accepted start");

    // Strobes only come out of an idle stretch
    strobe_while_ready: assert property (@(posedge clk) disable iff (!reset_n)
        result_strobe |-> ready && $past(ready))
        else $error("result_strobe pulsed while the array was busy");

    // Decimal points never light
    dp_off: assert property (@(posedge clk) disable iff (!reset_n)
        hex_connect[7] && hex_connect[15] && hex_connect[23] && hex_connect[31])
        else $error("a decimal point segment is driven on");

endmodule

bind sa_top sa_assert i_sa_assert (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .ready         (ready),
    .result_strobe (result_strobe),
    .hex_connect   (hex_connect)
);

// File: tests/sa_tb.sv
`timescale 1ns/100ps

module sa_tb;
    import sa_pkg::*;

    localparam int n_results      = array_w * array_w;
    localparam int ready_timeout  = 100;
    localparam int strobe_timeout = 4 * display_ticks;

    logic                    clk;
    logic                    reset_n;
    logic                    wr_en;
    logic                    wr_sel;
    logic [addr_width-1:0]   wr_addr;
    logic [data_width-1:0]   wr_data;
    logic                    start;
    logic                    ready;
    logic                    result_strobe;
    logic [4*data_width-1:0] hex_connect;

    logic [data_width-1:0]   a_model [mem_size];
    logic [data_width-1:0]   b_model [mem_size];
    logic [7:0]              seg_table [16];
    integer                  seed = 28;
    int                      errors;            // Current test only
    int                      total_errors;
    int                      tests_run;
    int                      tests_failed;

    tb_clock i_clock (.clk (clk));

    sa_top i_sa_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start         (start),
        .ready         (ready),
        .result_strobe (result_strobe),
        .hex_connect   (hex_connect)
    );

    // ==================================================
    // Model and display decoding
    // ==================================================
    function automatic int expected_c(input int idx);
        int row;
        int col;
        int sum;
        row = idx / array_w;
        col = idx % array_w;
        sum = 0;
        for (int k = 0; k < array_l; k++) begin
            sum += int'(a_model[row*array_l + k]) * int'(b_model[k*array_w + col]);
        end
        return sum % (1 << res_width);          // Wraps like the accumulators
    endfunction

    function automatic int decode_digit(input logic [7:0] code);
        for (int n = 0; n < 16; n++) begin
            if (seg_table[n] == code) begin
                return n;
            end
        end
        return -1;
    endfunction

    // Four digits back to one word, -1 on an unknown code
    function automatic int decode_display(input logic [4*data_width-1:0] hex);
        int value;
        int digit;
        value = 0;
        for (int d = 3; d >= 0; d--) begin
            digit = decode_digit(hex[8*d +: 8]);
            if (digit < 0) begin
                return -1;
            end
            value = value * 16 + digit;
        end
        return value;
    endfunction

    // ==================================================
    // Bus tasks
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic sel, input int addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_sel  = sel;
        wr_addr = addr_width'(addr);
        wr_data = data;
        next_cycle();
        wr_en   = 1'b0;
    endtask

    task automatic load_matrices(input bit all_max);
        logic [data_width-1:0] value;
        for (int n = 0; n < mem_size; n++) begin
            value = all_max ? 8'hFF : data_width'($random(seed));
            a_model[n] = value;
            write_word(1'b0, n, value);
            value = all_max ? 8'hFF : data_width'($random(seed));
            b_model[n] = value;
            write_word(1'b1, n, value);
        end
    endtask

    task automatic pulse_start();
        assert (ready) else begin
            $display("start was about to be issued while the DUT was busy");
            errors++;
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_ready();
        int count;
        count = 0;
        while (!ready && count < ready_timeout) begin
            next_cycle();
            count++;
        end
        assert (ready) else begin
            $display("ready did not rise within %0d cycles", ready_timeout);
            errors++;
        end
    endtask

    // Each strobe must show the next C entry in row-major order
    task automatic check_results(input int count);
        int waited;
        int shown;
        for (int idx = 0; idx < count; idx++) begin
            waited = 0;
            next_cycle();
            while (!result_strobe && waited < strobe_timeout) begin
                next_cycle();
                waited++;
            end
            assert (result_strobe) else begin
                $display("no result_strobe arrived for result %0d", idx);
                errors++;
            end
            if (!result_strobe) begin
                return;
            end
            shown = decode_display(hex_connect);
            assert (shown >= 0) else begin
                $display("hex_connect %h holds a segment code that is no hex digit",
                         hex_connect);
                errors++;
            end
            assert (shown < 0 || shown == expected_c(idx)) else begin
                $display("FAILED hex_connect C[%0d]: expected %h, got %h",
                         idx, 16'(expected_c(idx)), 16'(shown));
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += errors;
        if (errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        seg_table = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                      8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
        errors       = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_n      = 1'b0;
        wr_en        = 1'b0;
        wr_sel       = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        start        = 1'b0;

        repeat (5) @(posedge clk);
        #1;
        assert (!ready && !result_strobe) else begin
            $display("ready or result_strobe is high during reset");
            errors++;
        end
        reset_n = 1'b1;
        wait_ready();
        for (int n = 0; n < 2 * display_ticks; n++) begin
            assert (!result_strobe) else begin
                $display("result_strobe pulsed before any computation");
                errors++;
            end
            next_cycle();
        end
        assert (decode_display(hex_connect) == 0) else begin
            $display("FAILED hex_connect: expected %h, got %h", 32'hC0C0C0C0, hex_connect);
            errors++;
        end
        finish_test("reset_state");

        load_matrices(1'b0);
        pulse_start();
        wait_ready();
        check_results(n_results);
        finish_test("random_product");

        load_matrices(1'b1);
        pulse_start();
        wait_ready();
        check_results(n_results);
        finish_test("extreme_values");

        // Model stays as loaded, the DUT must drop these writes
        load_matrices(1'b0);
        pulse_start();
        for (int n = 0; n < 6; n++) begin
            assert (!ready) else begin
                $display("DUT turned idle before the busy writes were issued");
                errors++;
            end
            write_word(1'($random(seed)), $random(seed) & (mem_size - 1),
                       data_width'($random(seed)));
        end
        wait_ready();
        pulse_start();
        wait_ready();
        check_results(n_results);
        finish_test("writes_while_busy");

        load_matrices(1'b0);
        pulse_start();
        wait_ready();
        check_results(5);
        pulse_start();                          // Mid-display restart
        wait_ready();
        check_results(n_results);
        finish_test("restart_during_display");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

endmodule
